//--- verilog/dlc_regmap_pkg.sv
// level-crossing register map
`default_nettype none

package dlc_regmap_pkg;

  localparam int REG_DATA_W  = 32;  // register bus data width
  localparam int LOG_WL_W    = 4;   // shift amount, level width is 2**log_wl
  localparam int DLVL_BITS_W = 3;   // bit position of the direction flag in a packet

  // register offsets on the 8-bit address bus
  typedef enum logic [7:0] {
    ADDR_LOG_WL    = 8'h00,
    ADDR_DLVL_BITS = 8'h04,
    ADDR_MASK_DLVL = 8'h14,  // largest delta level carried by one packet
    ADDR_MASK_DT   = 8'h18   // largest delta time, also the overflow marker
  } reg_addr_e;

endpackage

`default_nettype wire

//--- verilog/dlc_core_pkg.sv
// level-crossing datapath definitions
`default_nettype none

package dlc_core_pkg;

  localparam int SAMPLE_W   = 16;  // signed input samples, levels share this width
  localparam int PKT_W      = 16;  // {delta time, direction | delta level}
  localparam int FIELD_W    = 8;   // one packet field, also mask width
  localparam int FIFO_DEPTH = 4;

  // encoder control states
  typedef enum logic [1:0] {
    ST_RUN,       // popping samples, one packet per crossing
    ST_DLVL_OVF,  // emitting continuation packets of a large jump
    ST_DT_OVF     // emitting a delta-time overflow packet
  } dlc_state_e;

endpackage

`default_nettype wire

//--- verilog/dlc_cfg_if.sv
// live configuration bundle
`timescale 1ns/1ps
`default_nettype none

interface dlc_cfg_if;

  logic [dlc_regmap_pkg::LOG_WL_W-1:0]    log_wl;     // sample >>> log_wl gives the level
  logic [dlc_regmap_pkg::DLVL_BITS_W-1:0] dlvl_bits;  // where the direction bit sits
  logic [dlc_core_pkg::FIELD_W-1:0]       mask_dlvl;
  logic [dlc_core_pkg::FIELD_W-1:0]       mask_dt;

  // register file side
  modport regs (output log_wl, dlvl_bits, mask_dlvl, mask_dt);

  // datapath side
  modport core (input log_wl, dlvl_bits, mask_dlvl, mask_dt);

endinterface

`default_nettype wire

//--- verilog/dlc_fifo.sv
// synchronous circular FIFO
`timescale 1ns/1ps
`default_nettype none

module dlc_fifo #(
  parameter int DEPTH = dlc_core_pkg::FIFO_DEPTH,
  parameter int WIDTH = dlc_core_pkg::PKT_W
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,   // head entry, valid while not empty
  output logic             full_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;
  logic             pop_ok;

  // wraps at DEPTH-1 so non power-of-two depths work too
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i && !full_o;   // push into a full buffer is dropped
  assign pop_ok  = pop_i && !empty_o;   // pop from an empty buffer is dropped
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_ok) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // both or neither, occupancy unchanged
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/dlc_regs.sv
// configuration register file
`timescale 1ns/1ps
`default_nettype none

module dlc_regs (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         reg_valid_i,
  input  logic                                         reg_write_i,
  input  logic [$bits(dlc_regmap_pkg::reg_addr_e)-1:0] reg_addr_i,
  input  logic [dlc_regmap_pkg::REG_DATA_W-1:0]        reg_wdata_i,
  output logic [dlc_regmap_pkg::REG_DATA_W-1:0]        reg_rdata_o,
  output logic                                         reg_error_o,
  dlc_cfg_if.regs                                      cfg
);

  logic [dlc_regmap_pkg::LOG_WL_W-1:0]    log_wl_q;
  logic [dlc_regmap_pkg::DLVL_BITS_W-1:0] dlvl_bits_q;
  logic [dlc_core_pkg::FIELD_W-1:0]       mask_dlvl_q;
  logic [dlc_core_pkg::FIELD_W-1:0]       mask_dt_q;

  // write decode, only the low bits of each field are kept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      log_wl_q    <= '0;
      dlvl_bits_q <= '0;
      mask_dlvl_q <= '0;
      mask_dt_q   <= '0;
    end else if (reg_valid_i && reg_write_i) begin
      case (reg_addr_i)
        dlc_regmap_pkg::ADDR_LOG_WL:
          log_wl_q <= reg_wdata_i[dlc_regmap_pkg::LOG_WL_W-1:0];
        dlc_regmap_pkg::ADDR_DLVL_BITS:
          dlvl_bits_q <= reg_wdata_i[dlc_regmap_pkg::DLVL_BITS_W-1:0];
        dlc_regmap_pkg::ADDR_MASK_DLVL:
          mask_dlvl_q <= reg_wdata_i[dlc_core_pkg::FIELD_W-1:0];
        dlc_regmap_pkg::ADDR_MASK_DT:
          mask_dt_q <= reg_wdata_i[dlc_core_pkg::FIELD_W-1:0];
        default: ;  // unmapped offset, write dropped
      endcase
    end
  end

  // read mux, answers the current request in the same cycle
  always_comb begin
    reg_rdata_o = '0;  // zero-extend every field
    reg_error_o = 1'b0;
    if (reg_valid_i) begin
      case (reg_addr_i)
        dlc_regmap_pkg::ADDR_LOG_WL:    reg_rdata_o[dlc_regmap_pkg::LOG_WL_W-1:0] = log_wl_q;
        dlc_regmap_pkg::ADDR_DLVL_BITS: reg_rdata_o[dlc_regmap_pkg::DLVL_BITS_W-1:0] = dlvl_bits_q;
        dlc_regmap_pkg::ADDR_MASK_DLVL: reg_rdata_o[dlc_core_pkg::FIELD_W-1:0] = mask_dlvl_q;
        dlc_regmap_pkg::ADDR_MASK_DT:   reg_rdata_o[dlc_core_pkg::FIELD_W-1:0] = mask_dt_q;
        default:                        reg_error_o = 1'b1;  // no such register
      endcase
    end
  end

  assign cfg.log_wl    = log_wl_q;
  assign cfg.dlvl_bits = dlvl_bits_q;
  assign cfg.mask_dlvl = mask_dlvl_q;
  assign cfg.mask_dt   = mask_dt_q;

endmodule

`default_nettype wire

//--- verilog/dlc_ctrl_fsm.sv
// encoder control FSM
`timescale 1ns/1ps
`default_nettype none

module dlc_ctrl_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    in_empty_i,
  input  logic                    out_full_i,
  input  logic                    xing_i,      // current sample crosses a level
  input  logic                    dlvl_ovf_i,  // crossing too large for one packet
  input  logic                    ovf_end_i,   // last split packet leaves now
  input  logic                    dt_wrap_i,   // skip count hit mask_dt
  output logic                    take_o,
  output logic                    push_o,
  output logic                    out_room_o,
  output logic                    dt_flush_o,
  output dlc_core_pkg::dlc_state_e state_o
);

  dlc_core_pkg::dlc_state_e state_q;
  dlc_core_pkg::dlc_state_e state_d;

  assign out_room_o = !out_full_i;
  assign state_o    = state_q;

  // samples are only consumed in RUN, and only when a packet could leave with them
  assign take_o = (state_q == dlc_core_pkg::ST_RUN) && !in_empty_i && out_room_o;

  assign push_o = out_room_o && ((xing_i && state_q == dlc_core_pkg::ST_RUN) ||
                                 dlvl_ovf_i ||                         // first split packet
                                 state_q == dlc_core_pkg::ST_DLVL_OVF ||
                                 state_q == dlc_core_pkg::ST_DT_OVF);

  assign dt_flush_o = (state_q == dlc_core_pkg::ST_DT_OVF) && out_room_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dlc_core_pkg::ST_RUN: begin
        if (dlvl_ovf_i && out_room_o) state_d = dlc_core_pkg::ST_DLVL_OVF;
        else if (dt_wrap_i) state_d = dlc_core_pkg::ST_DT_OVF;
      end
      dlc_core_pkg::ST_DLVL_OVF: if (ovf_end_i) state_d = dlc_core_pkg::ST_RUN;
      dlc_core_pkg::ST_DT_OVF:   if (out_room_o) state_d = dlc_core_pkg::ST_RUN;  // packet gone
      default:                   state_d = dlc_core_pkg::ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= dlc_core_pkg::ST_RUN;
    else state_q <= state_d;
  end

endmodule

`default_nettype wire

//--- verilog/dlc_skip_counter.sv
// skipped-sample counter
`timescale 1ns/1ps
`default_nettype none

module dlc_skip_counter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             take_i,
  input  logic                             xing_i,
  input  logic                             dt_flush_i,  // overflow packet leaving
  dlc_cfg_if.core                          cfg,
  output logic [dlc_core_pkg::FIELD_W-1:0] skip_cnt_o,
  output logic                             dt_wrap_o
);

  logic [dlc_core_pkg::FIELD_W-1:0] cnt_q;
  logic                             count_en;

  assign count_en   = take_i && !xing_i;  // sample taken but stays in the current level
  assign dt_wrap_o  = count_en && (cnt_q == cfg.mask_dt);
  assign skip_cnt_o = cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cnt_q <= '0;
    else if (xing_i || dt_flush_i) cnt_q <= '0;  // restart after any packet with a time stamp
    else if (count_en) cnt_q <= cnt_q + 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/dlc_delta_encoder.sv
// level detection and packet builder
`timescale 1ns/1ps
`default_nettype none

module dlc_delta_encoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              take_i,       // sample at the FIFO head is valid
  input  logic [dlc_core_pkg::SAMPLE_W-1:0] in_data_i,
  input  dlc_core_pkg::dlc_state_e          state_i,
  input  logic                              out_room_i,
  input  logic [dlc_core_pkg::FIELD_W-1:0]  skip_cnt_i,
  dlc_cfg_if.core                           cfg,
  output logic                              xing_o,
  output logic                              dlvl_ovf_o,
  output logic                              ovf_end_o,
  output logic [dlc_core_pkg::PKT_W-1:0]    pkt_o
);

  localparam int LVL_W = dlc_core_pkg::SAMPLE_W;
  localparam int FLD_W = dlc_core_pkg::FIELD_W;

  logic signed [LVL_W-1:0] din_lvl;
  logic signed [LVL_W-1:0] curr_lvl_q;
  logic signed [LVL_W-1:0] dlvl;
  logic        [LVL_W-1:0] dlvl_abs;
  logic                    dir;          // 1 = downward step
  logic                    dir_q;        // direction held over a split
  logic        [LVL_W:0]   mask_ext;     // extra bit so the sign of the remainder shows
  logic        [LVL_W:0]   split_q;      // magnitude still to send
  logic        [LVL_W:0]   split_op;
  logic        [LVL_W:0]   split_nxt;
  logic                    in_split;
  logic                    split_last;
  logic        [FLD_W-1:0] mag_out;
  logic        [FLD_W-1:0] dt_out;
  logic        [FLD_W-1:0] dir_field;
  logic                    dir_out;

  assign din_lvl = $signed(in_data_i) >>> cfg.log_wl;  // arithmetic, keeps the sign
  assign dlvl    = take_i ? (din_lvl - curr_lvl_q) : '0;
  assign xing_o  = (dlvl != '0);
  assign dir     = dlvl[LVL_W-1];
  assign dlvl_abs = dir ? -dlvl : dlvl;

  assign mask_ext   = {{(LVL_W + 1 - FLD_W){1'b0}}, cfg.mask_dlvl};
  assign dlvl_ovf_o = xing_o && ({1'b0, dlvl_abs} > mask_ext);

  // first split step works on the fresh magnitude, later ones on the remainder
  assign split_op   = dlvl_ovf_o ? {1'b0, dlvl_abs} : split_q;
  assign split_nxt  = split_op - mask_ext;
  assign in_split   = (state_i == dlc_core_pkg::ST_DLVL_OVF);
  assign split_last = in_split && split_nxt[LVL_W];  // remainder below the mask
  assign ovf_end_o  = split_last && out_room_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      curr_lvl_q <= '0;
      split_q    <= '0;
      dir_q      <= 1'b0;
    end else begin
      if (xing_o) curr_lvl_q <= din_lvl;  // follow the sample's level
      if (out_room_i && (dlvl_ovf_o || in_split)) split_q <= split_nxt;
      if (dlvl_ovf_o) dir_q <= dir;
    end
  end

  // field select, plain crossing by default
  always_comb begin
    mag_out = dlvl_abs[FLD_W-1:0];
    dir_out = dir;
    dt_out  = skip_cnt_i;
    if (state_i == dlc_core_pkg::ST_DT_OVF) begin
      mag_out = '0;  // time-only marker
      dir_out = 1'b0;
      dt_out  = cfg.mask_dt;
    end else if (dlvl_ovf_o) begin
      mag_out = cfg.mask_dlvl;  // first chunk keeps the skip count
    end else if (in_split) begin
      mag_out = split_last ? split_op[FLD_W-1:0] : cfg.mask_dlvl;
      dir_out = dir_q;
      dt_out  = '0;  // continuation packets follow with no time gap
    end
  end

  assign dir_field = FLD_W'(dir_out) << cfg.dlvl_bits;
  assign pkt_o     = {dt_out, mag_out | dir_field};

endmodule

`default_nettype wire

//--- verilog/dlc_top.sv
// level-crossing encoder top
`timescale 1ns/1ps
`default_nettype none

module dlc_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // register bus
  input  logic                                         reg_valid_i,
  input  logic                                         reg_write_i,
  input  logic [$bits(dlc_regmap_pkg::reg_addr_e)-1:0] reg_addr_i,
  input  logic [dlc_regmap_pkg::REG_DATA_W-1:0]        reg_wdata_i,
  output logic [dlc_regmap_pkg::REG_DATA_W-1:0]        reg_rdata_o,
  output logic                                         reg_error_o,
  // sample stream in
  input  logic                                         in_push_i,
  input  logic [dlc_core_pkg::SAMPLE_W-1:0]            in_data_i,
  output logic                                         in_full_o,
  // packet stream out
  input  logic                                         out_pop_i,
  output logic [dlc_core_pkg::PKT_W-1:0]               out_data_o,
  output logic                                         out_empty_o
);

  logic                              in_empty;
  logic [dlc_core_pkg::SAMPLE_W-1:0] in_head;   // sample at the input FIFO head
  logic                              out_full;
  logic                              take;      // pop input, sample is valid
  logic                              push;
  logic                              out_room;
  logic                              dt_flush;
  dlc_core_pkg::dlc_state_e          state;
  logic [dlc_core_pkg::FIELD_W-1:0]  skip_cnt;
  logic                              dt_wrap;
  logic                              xing;
  logic                              dlvl_ovf;
  logic                              ovf_end;
  logic [dlc_core_pkg::PKT_W-1:0]    pkt;

  dlc_cfg_if cfg_if ();

  dlc_regs u_regs (
    .clk_i, .rst_ni, .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_error_o, .cfg(cfg_if)
  );

  dlc_fifo #(.DEPTH(dlc_core_pkg::FIFO_DEPTH), .WIDTH(dlc_core_pkg::SAMPLE_W)) u_in_fifo (
    .clk_i, .rst_ni, .push_i(in_push_i), .data_i(in_data_i), .pop_i(take),
    .data_o(in_head), .full_o(in_full_o), .empty_o(in_empty)
  );

  dlc_fifo #(.DEPTH(dlc_core_pkg::FIFO_DEPTH), .WIDTH(dlc_core_pkg::PKT_W)) u_out_fifo (
    .clk_i, .rst_ni, .push_i(push), .data_i(pkt), .pop_i(out_pop_i),
    .data_o(out_data_o), .full_o(out_full), .empty_o(out_empty_o)
  );

  dlc_ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .in_empty_i(in_empty), .out_full_i(out_full),
    .xing_i(xing), .dlvl_ovf_i(dlvl_ovf), .ovf_end_i(ovf_end), .dt_wrap_i(dt_wrap),
    .take_o(take), .push_o(push), .out_room_o(out_room), .dt_flush_o(dt_flush),
    .state_o(state)
  );

  dlc_skip_counter u_skip_cnt (
    .clk_i, .rst_ni, .take_i(take), .xing_i(xing), .dt_flush_i(dt_flush),
    .cfg(cfg_if), .skip_cnt_o(skip_cnt), .dt_wrap_o(dt_wrap)
  );

  dlc_delta_encoder u_enc (
    .clk_i, .rst_ni, .take_i(take), .in_data_i(in_head), .state_i(state),
    .out_room_i(out_room), .skip_cnt_i(skip_cnt), .cfg(cfg_if),
    .xing_o(xing), .dlvl_ovf_o(dlvl_ovf), .ovf_end_o(ovf_end), .pkt_o(pkt)
  );

endmodule

`default_nettype wire

//--- tests/tb_dlc.sv
// level-crossing encoder testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dlc;

  localparam int CLK_PERIOD   = 10;
  localparam int WAIT_LIMIT   = 400;   // idle cycles before a wait gives up
  localparam int BUDGET_REGS  = 100;   // per-test cycle budgets
  localparam int BUDGET_RAMP  = 800;
  localparam int BUDGET_DT    = 1200;
  localparam int BUDGET_SPLIT = 400;
  localparam int BUDGET_BP    = 2000;
  localparam int BUDGET_ALL   = BUDGET_REGS + BUDGET_RAMP + BUDGET_DT + BUDGET_SPLIT
                              + BUDGET_BP + 20;  // plus reset and final idle check

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        reg_valid_i;
  logic        reg_write_i;
  logic [7:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        reg_error_o;
  logic        in_push_i;
  logic [15:0] in_data_i;
  logic        in_full_o;
  logic        out_pop_i;
  logic [15:0] out_data_o;
  logic        out_empty_o;

  logic [15:0] stim_q [$];  // samples of the current test
  logic [15:0] exp_q [$];   // packets predicted by the model
  logic [15:0] got_q [$];   // packets drained from the DUT
  logic [15:0] lfsr_q = 16'd75;
  int          err_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  // reference model state that mirrors the DUT across tests
  int          m_log_wl = 0;
  int          m_dlvl_bits = 0;
  int          m_mask_dlvl = 0;
  int          m_mask_dt = 0;
  int          m_level = 0;
  int          m_cnt = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  dlc_top u_dut (
    .clk_i, .rst_ni, .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_error_o, .in_push_i, .in_data_i, .in_full_o,
    .out_pop_i, .out_data_o, .out_empty_o
  );

  task automatic check_pkt(input string name, input logic [dlc_core_pkg::PKT_W-1:0] got,
                           input logic [dlc_core_pkg::PKT_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%04h, expected 0x%04h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_reg(input string name, input logic [dlc_regmap_pkg::REG_DATA_W-1:0] got,
                           input logic [dlc_regmap_pkg::REG_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, err_count - errs_before);
    end
  endtask

  // galois form with taps at 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // 9 random bits sign-extended so a delta needs only a few packets
  function automatic logic [15:0] random_sample();
    logic [8:0] bits;
    int         i;
    bits = '0;
    for (i = 0; i < 9; i++) begin
      bits   = {bits[7:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
    end
    return {{7{bits[8]}}, bits};
  endfunction

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b0;
    reg_addr_i  <= addr;
    @(negedge clk_i);  // response is combinational
    data = reg_rdata_o;
    err  = reg_error_o;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
  endtask

  task automatic configure(input int log_wl, input int dlvl_bits, input int mask_dlvl,
                           input int mask_dt);
    reg_write(8'h00, 32'(log_wl));
    reg_write(8'h04, 32'(dlvl_bits));
    reg_write(8'h14, 32'(mask_dlvl));
    reg_write(8'h18, 32'(mask_dt));
    m_log_wl    = log_wl;
    m_dlvl_bits = dlvl_bits;
    m_mask_dlvl = mask_dlvl;
    m_mask_dt   = mask_dt;
  endtask

  // turns stim_q into the packets the encoder must emit
  task automatic build_expected();
    int         lvl;
    int         d;
    int         mag;
    int         k;
    logic [7:0] dir_f;
    foreach (stim_q[i]) begin
      lvl = int'($signed(stim_q[i])) >>> m_log_wl;
      d   = lvl - m_level;
      if (d == 0) begin
        if (m_cnt == m_mask_dt) begin
          exp_q.push_back({8'(m_mask_dt), 8'h00});  // time-only marker and the count restarts
          m_cnt = 0;
        end else begin
          m_cnt++;
        end
      end else begin
        mag   = (d < 0) ? -d : d;
        dir_f = 8'(d < 0) << m_dlvl_bits;  // 1 = down
        if (mag <= m_mask_dlvl) begin
          exp_q.push_back({8'(m_cnt), 8'(mag) | dir_f});
        end else begin
          exp_q.push_back({8'(m_cnt), 8'(m_mask_dlvl) | dir_f});  // only this one has dt
          for (k = 1; k < mag / m_mask_dlvl; k++) begin
            exp_q.push_back({8'h00, 8'(m_mask_dlvl) | dir_f});
          end
          exp_q.push_back({8'h00, 8'(mag % m_mask_dlvl) | dir_f});  // remainder which may be 0
        end
        m_cnt   = 0;
        m_level = lvl;
      end
    end
  endtask

  task automatic push_samples();
    int idle;
    foreach (stim_q[i]) begin
      idle = 0;
      @(negedge clk_i);
      while (in_full_o && idle < WAIT_LIMIT) begin
        idle++;
        @(negedge clk_i);
      end
      if (in_full_o) begin
        $display("input FIFO stayed full, sample %0d was never accepted", i);
        err_count++;
        return;
      end
      @(posedge clk_i);
      in_push_i <= 1'b1;
      in_data_i <= stim_q[i];
      @(posedge clk_i);
      in_push_i <= 1'b0;
    end
  endtask

  task automatic drain_packets(input bit hold_pop);
    int idle;
    idle = 0;
    if (hold_pop) begin
      do begin
        @(negedge clk_i);
        idle++;
      end while (!in_full_o && idle < WAIT_LIMIT);
      if (!in_full_o) begin
        $display("in_full_o never rose while the output was held back");
        err_count++;
      end
      idle = 0;
    end
    while (got_q.size() < exp_q.size() && idle < WAIT_LIMIT) begin
      @(negedge clk_i);
      if (!out_empty_o) begin
        got_q.push_back(out_data_o);  // head is valid while not empty
        idle = 0;
        @(posedge clk_i);
        out_pop_i <= 1'b1;
        @(posedge clk_i);
        out_pop_i <= 1'b0;
      end else begin
        idle++;
      end
    end
    if (got_q.size() < exp_q.size()) begin
      $display("timed out waiting for packets, %0d of %0d arrived", got_q.size(), exp_q.size());
      err_count++;
    end
  endtask

  task automatic run_stream(input string name, input bit hold_pop);
    int errs_before;
    errs_before = err_count;
    exp_q.delete();
    got_q.delete();
    build_expected();
    fork
      push_samples();
      drain_packets(hold_pop);
    join
    if (got_q.size() != exp_q.size()) begin
      $display("%s: expected %0d packets, received %0d", name, exp_q.size(), got_q.size());
      err_count++;
    end
    foreach (got_q[i]) begin
      check_pkt($sformatf("out_data_o[%0d]", i), got_q[i], exp_q[i]);
    end
    report_test(name, errs_before);
  endtask

  task automatic test_registers();
    logic [7:0]  addr [4];
    logic [31:0] wdata [4];
    int          width [4];
    logic [31:0] rdata;
    logic        err;
    int          errs_before;
    errs_before = err_count;
    addr  = '{8'h00, 8'h04, 8'h14, 8'h18};
    width = '{4, 3, 8, 8};  // log_wl, dlvl_bits, mask_dlvl, mask_dt
    wdata = '{32'hFFFF_FFF9, 32'h8000_0006, 32'h1234_56A5, 32'h0000_01C3};
    @(negedge clk_i);
    check_flag("in_full_o", in_full_o, 1'b0);  // both FIFOs start empty
    check_flag("out_empty_o", out_empty_o, 1'b1);
    foreach (addr[i]) begin
      reg_read(addr[i], rdata, err);
      check_reg($sformatf("reg_rdata_o@0x%02h", addr[i]), rdata, 32'h0);  // configuration resets to 0
    end
    foreach (addr[i]) reg_write(addr[i], wdata[i]);
    foreach (addr[i]) begin
      reg_read(addr[i], rdata, err);
      check_reg($sformatf("reg_rdata_o@0x%02h", addr[i]), rdata,
                wdata[i] & ((32'd1 << width[i]) - 1));
      check_flag($sformatf("reg_error_o@0x%02h", addr[i]), err, 1'b0);
    end
    reg_read(8'h08, rdata, err);  // hole in the map
    check_flag("reg_error_o@0x08", err, 1'b1);
    report_test("registers", errs_before);
  endtask

  task automatic test_ramp();
    int s;
    int i;
    stim_q.delete();
    s = 0;
    for (i = 0; i < 24; i++) begin
      if (i % 5 == 3) s -= 70;       // about four levels down
      else if (i % 4 == 1) s += 3;   // mostly stays in its level
      else s += 37;
      stim_q.push_back(16'(s));
    end
    run_stream("ramp", 1'b0);
  endtask

  task automatic test_dt_overflow();
    stim_q.delete();
    repeat (37) stim_q.push_back(16'd80);  // level 5 for long enough to wrap the skip count twice
    stim_q.push_back(16'd112);             // level 7 after the count restarted
    run_stream("dt_overflow", 1'b0);
  endtask

  task automatic test_split();
    stim_q.delete();
    stim_q.push_back(16'd112);
    stim_q.push_back(16'd112);
    stim_q.push_back(16'hFF30);  // -208 is level -13 so the jump is twenty levels down
    run_stream("dlvl_split", 1'b0);
  endtask

  task automatic test_backpressure();
    stim_q.delete();
    repeat (40) stim_q.push_back(random_sample());
    run_stream("backpressure", 1'b1);
  endtask

  initial begin
    #(BUDGET_ALL * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run is stuck", BUDGET_ALL);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_ni      <= 1'b0;
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
    reg_addr_i  <= '0;
    reg_wdata_i <= '0;
    in_push_i   <= 1'b0;
    in_data_i   <= '0;
    out_pop_i   <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_registers();
    configure(4, 3, 7, 15);
    test_ramp();
    test_dt_overflow();
    test_split();
    test_backpressure();
    repeat (4) @(negedge clk_i);
    check_flag("out_empty_o", out_empty_o, 1'b1);  // no stray packets left behind
    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dlc.f
verilog/dlc_regmap_pkg.sv
verilog/dlc_core_pkg.sv
verilog/dlc_cfg_if.sv
verilog/dlc_fifo.sv
verilog/dlc_regs.sv
verilog/dlc_ctrl_fsm.sv
verilog/dlc_skip_counter.sv
verilog/dlc_delta_encoder.sv
verilog/dlc_top.sv
tests/tb_dlc.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_dlc
FILELIST := dlc.f
OBJ_DIR  := obj_dir
PASS_MSG := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status follows the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
